/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Verification failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
design/rv_pkg.sv
design/ex_req_if.sv
design/stage_bus_if.sv
design/alu.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/rv_core_top.sv
sim/tb_checker.sv
sim/tb_top.sv

/* design/alu.sv */
module alu (
    input  logic [rv_pkg::ALU_OP_W-1:0] op_i,
    input  logic [rv_pkg::XLEN-1:0]     a_i,
    input  logic [rv_pkg::XLEN-1:0]     b_i,
    output logic [rv_pkg::XLEN-1:0]     result_o
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = '0;
        endcase
    end

endmodule

/* design/decode_stage.sv */
module decode_stage (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          instr_valid_i,
    input  rv_pkg::instr_u                instr_i,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
    ex_req_if.decoder                     req
);
    import rv_pkg::*;

    logic                if_id_valid;
    instr_u              if_id_instr;
    logic                is_op;
    logic                is_op_imm;
    logic                legal;
    logic                dec_valid;
    logic [ALU_OP_W-1:0] dec_alu_op;
    logic [XLEN-1:0]     dec_imm;

    // IF/ID
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id_valid <= 1'b0;
        end else begin
            if_id_valid <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if_id_instr <= instr_i;
    end

    assign is_op     = if_id_instr.r_fmt.opcode == OPC_OP;
    assign is_op_imm = if_id_instr.i_fmt.opcode == OPC_OP_IMM;

    // funct7 must be zero except for SUB, SRA and SRAI
    always_comb begin
        legal = 1'b0;
        if (is_op) begin
            legal = (if_id_instr.r_fmt.funct7 == 7'b0000000) ||
                    (if_id_instr.r_fmt.funct7 == 7'b0100000 &&
                     (if_id_instr.r_fmt.funct3 == 3'd0 || if_id_instr.r_fmt.funct3 == 3'd5));
        end else if (is_op_imm) begin
            case (if_id_instr.i_fmt.funct3)
                3'd1:    legal = if_id_instr.i_fmt.imm12[11:5] == 7'b0000000;
                3'd5:    legal = if_id_instr.i_fmt.imm12[11:5] == 7'b0000000 ||
                                 if_id_instr.i_fmt.imm12[11:5] == 7'b0100000;
                default: legal = 1'b1;
            endcase
        end
    end

    assign dec_valid = if_id_valid && legal && (if_id_instr.r_fmt.rd != '0);

    // Bit 30 picks SUB for R-type only, SRA for both formats
    always_comb begin
        case (if_id_instr.r_fmt.funct3)
            3'd0:    dec_alu_op = (is_op && if_id_instr.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'd1:    dec_alu_op = ALU_SLL;
            3'd2:    dec_alu_op = ALU_SLT;
            3'd3:    dec_alu_op = ALU_SLTU;
            3'd4:    dec_alu_op = ALU_XOR;
            3'd5:    dec_alu_op = if_id_instr.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
            3'd6:    dec_alu_op = ALU_OR;
            default: dec_alu_op = ALU_AND;
        endcase
    end

    assign dec_imm    = {{(XLEN-12){if_id_instr.i_fmt.imm12[11]}}, if_id_instr.i_fmt.imm12};
    assign rs1_addr_o = if_id_instr.r_fmt.rs1;
    assign rs2_addr_o = if_id_instr.r_fmt.rs2;

    // ID/EX
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        req.rd      <= if_id_instr.r_fmt.rd;
        req.rs1     <= if_id_instr.r_fmt.rs1;
        req.rs2     <= if_id_instr.r_fmt.rs2;
        req.alu_op  <= dec_alu_op;
        req.op_a    <= rs1_data_i;
        req.op_b    <= rs2_data_i;
        req.use_imm <= is_op_imm;
        req.imm     <= dec_imm;
    end

    a_valid_rd_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n_i) req.valid |-> req.rd != '0
    );

endmodule

/* design/ex_req_if.sv */
interface ex_req_if;
    import rv_pkg::*;

    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [ALU_OP_W-1:0]   alu_op;
    // Register file values as read in decode
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic                  use_imm;
    logic [XLEN-1:0]       imm;

    modport decoder (
        output valid, rd, rs1, rs2, alu_op, op_a, op_b, use_imm, imm
    );

    modport executor (
        input valid, rd, rs1, rs2, alu_op, op_a, op_b, use_imm, imm
    );

endinterface

/* design/execute_stage.sv */
module execute_stage (
    input  logic       clk,
    input  logic       arst_n_i,
    ex_req_if.executor req,
    stage_bus_if.exec  bus
);
    import rv_pkg::*;

    logic [XLEN-1:0] fwd_a;
    logic [XLEN-1:0] fwd_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;

    // EX/MEM wins over MEM/WB when both hold the register
    always_comb begin
        if (bus.ex_mem_valid && bus.ex_mem_rd == req.rs1) begin
            fwd_a = bus.ex_mem_data;
        end else if (bus.mem_wb_valid && bus.mem_wb_rd == req.rs1) begin
            fwd_a = bus.mem_wb_data;
        end else begin
            fwd_a = req.op_a;
        end
    end

    always_comb begin
        if (bus.ex_mem_valid && bus.ex_mem_rd == req.rs2) begin
            fwd_b = bus.ex_mem_data;
        end else if (bus.mem_wb_valid && bus.mem_wb_rd == req.rs2) begin
            fwd_b = bus.mem_wb_data;
        end else begin
            fwd_b = req.op_b;
        end
    end

    assign alu_b = req.use_imm ? req.imm : fwd_b;

    alu u_alu (
        .op_i     (req.alu_op),
        .a_i      (fwd_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    // EX/MEM
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ex_mem_valid <= 1'b0;
        end else begin
            bus.ex_mem_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        bus.ex_mem_rd   <= req.rd;
        bus.ex_mem_data <= alu_result;
    end

    a_ex_mem_data_known: assert property (
        @(posedge clk) disable iff (!arst_n_i) bus.ex_mem_valid |-> !$isunknown(bus.ex_mem_data)
    );

endmodule

/* design/register_file.sv */
module register_file (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    // Write-first read port, x0 hardwired to zero
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads follow the array and the write port as well as the address
    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

/* design/rv_core_top.sv */
module rv_core_top (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          instr_valid_i,
    input  logic [rv_pkg::XLEN-1:0]       instr_i,
    output logic                          wb_valid_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o
);
    import rv_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    ex_req_if    req_if ();
    stage_bus_if bus_if ();

    decode_stage u_decode (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .req           (req_if.decoder)
    );

    // Written from MEM/WB one edge after retirement
    register_file u_regfile (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (bus_if.mem_wb_valid),
        .waddr_i    (bus_if.mem_wb_rd),
        .wdata_i    (bus_if.mem_wb_data)
    );

    execute_stage u_execute (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req      (req_if.executor),
        .bus      (bus_if.exec)
    );

    writeback_stage u_writeback (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (bus_if.retire)
    );

    assign wb_valid_o = bus_if.mem_wb_valid;
    assign wb_rd_o    = bus_if.mem_wb_rd;
    assign wb_data_o  = bus_if.mem_wb_data;

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;

    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // One instruction word, seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_fmt;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
    } instr_u;

endpackage

/* design/stage_bus_if.sv */
interface stage_bus_if;
    import rv_pkg::*;

    logic                  ex_mem_valid;
    logic [REG_ADDR_W-1:0] ex_mem_rd;
    logic [XLEN-1:0]       ex_mem_data;
    logic                  mem_wb_valid;
    logic [REG_ADDR_W-1:0] mem_wb_rd;
    logic [XLEN-1:0]       mem_wb_data;

    modport exec (
        output ex_mem_valid, ex_mem_rd, ex_mem_data,
        input  mem_wb_valid, mem_wb_rd, mem_wb_data
    );

    modport retire (
        input  ex_mem_valid, ex_mem_rd, ex_mem_data,
        output mem_wb_valid, mem_wb_rd, mem_wb_data
    );

endinterface

/* design/writeback_stage.sv */
module writeback_stage (
    input  logic        clk,
    input  logic        arst_n_i,
    stage_bus_if.retire bus
);

    // MEM/WB, no memory access in this core
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.mem_wb_valid <= 1'b0;
        end else begin
            bus.mem_wb_valid <= bus.ex_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        bus.mem_wb_rd   <= bus.ex_mem_rd;
        bus.mem_wb_data <= bus.ex_mem_data;
    end

    // A retirement must come from an EX/MEM entry of the previous cycle
    a_retire_has_source: assert property (
        @(posedge clk) disable iff (!arst_n_i) bus.mem_wb_valid |-> $past(bus.ex_mem_valid)
    );

endmodule

/* sim/tb_checker.sv */
module tb_checker (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          instr_valid_i,
    input  rv_pkg::instr_u                instr_i,
    input  logic                          wb_valid_o,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    input  logic [rv_pkg::XLEN-1:0]       wb_data_o,
    output int                            errors_o,
    output int                            checks_o
);
    import rv_pkg::*;

    logic [XLEN-1:0]       model_regs [32];
    logic [XLEN-1:0]       exp_data_q [$];
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    int                    exp_due_q [$];
    logic [XLEN-1:0]       result;
    int                    cycle = 0;
    int                    errors = 0;
    int                    checks = 0;

    assign errors_o = errors;
    assign checks_o = checks;

    // RV32I OP and OP-IMM encodings
    function automatic logic is_supported(input instr_u w);
        if (w.r_fmt.opcode == OPC_OP) begin
            return w.r_fmt.funct7 == 7'h00 ||
                   (w.r_fmt.funct7 == 7'h20 && (w.r_fmt.funct3 == 3'd0 || w.r_fmt.funct3 == 3'd5));
        end
        if (w.i_fmt.opcode == OPC_OP_IMM) begin
            if (w.i_fmt.funct3 == 3'd1) begin
                return w.i_fmt.imm12[11:5] == 7'h00;
            end
            if (w.i_fmt.funct3 == 3'd5) begin
                return w.i_fmt.imm12[11:5] == 7'h00 || w.i_fmt.imm12[11:5] == 7'h20;
            end
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [XLEN-1:0] model_result(input instr_u w);
        logic            is_r;
        logic            alt;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        is_r = w.r_fmt.opcode == OPC_OP;
        a    = model_regs[w.r_fmt.rs1];
        b    = is_r ? model_regs[w.r_fmt.rs2] : {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
        // Bit 30 of the word
        alt  = is_r ? w.r_fmt.funct7[5] : w.i_fmt.imm12[10];
        case (w.r_fmt.funct3)
            3'd0:    return (is_r && alt) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic drop_front();
        void'(exp_data_q.pop_front());
        void'(exp_rd_q.pop_front());
        void'(exp_due_q.pop_front());
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (wb_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                errors = errors + 1;
                $display("Write-back of x%0d at time %0t with no instruction pending",
                         wb_rd_o, $time);
            end else begin
                checks = checks + 1;
                if (wb_rd_o !== exp_rd_q[0]) begin
                    errors = errors + 1;
                    $display("Fail at time %0t: wb_rd_o expected %0d, actual %0d",
                             $time, exp_rd_q[0], wb_rd_o);
                end
                if (wb_data_o !== exp_data_q[0]) begin
                    errors = errors + 1;
                    $display("Fail at time %0t: wb_data_o expected %h, actual %h",
                             $time, exp_data_q[0], wb_data_o);
                end
                if (exp_due_q[0] != cycle) begin
                    errors = errors + 1;
                    $display("Write-back of x%0d at time %0t came in cycle %0d, due in cycle %0d",
                             wb_rd_o, $time, cycle, exp_due_q[0]);
                end
                drop_front();
            end
        end
        while (exp_due_q.size() > 0 && exp_due_q[0] <= cycle) begin
            errors = errors + 1;
            $display("Expected write-back of x%0d due in cycle %0d never arrived",
                     exp_rd_q[0], exp_due_q[0]);
            drop_front();
        end
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else if (instr_valid_i && is_supported(instr_i) && instr_i.r_fmt.rd != '0) begin
            // Model runs in program order, four cycles ahead of retirement
            result = model_result(instr_i);
            model_regs[instr_i.r_fmt.rd] = result;
            exp_data_q.push_back(result);
            exp_rd_q.push_back(instr_i.r_fmt.rd);
            exp_due_q.push_back(cycle + 4);
        end
    end

endmodule

/* sim/tb_top.sv */
module tb_top;
    import rv_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 8;
    localparam int N_RAND       = 150;
    localparam int N_SPECIAL    = 24;
    localparam int N_TOTAL      = 3 * N_RAND + N_SPECIAL + 4;

    logic                  clk;
    logic                  arst_n_i;
    logic                  instr_valid_i;
    logic [XLEN-1:0]       instr_i;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;
    logic [31:0]           rng;
    logic [31:0]           word;
    int                    top_errors;
    int                    chk_errors;
    int                    chk_checks;
    int                    err_mark;
    int                    tests_done;

    rv_core_top uut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    tb_checker chk (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .errors_o      (chk_errors),
        .checks_o      (chk_checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((N_TOTAL * 8 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Registers x1 to x4 only, to keep producers close to consumers
    function automatic logic [31:0] r_word(input logic [31:0] r);
        instr_u w;
        w.r_fmt.opcode = OPC_OP;
        w.r_fmt.funct3 = r[2:0];
        w.r_fmt.funct7 = (r[3] && (r[2:0] == 3'd0 || r[2:0] == 3'd5)) ? 7'h20 : 7'h00;
        w.r_fmt.rd     = {3'b000, r[5:4]} + 5'd1;
        w.r_fmt.rs1    = {3'b000, r[7:6]} + 5'd1;
        w.r_fmt.rs2    = {3'b000, r[9:8]} + 5'd1;
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [31:0] r);
        instr_u w;
        w.i_fmt.opcode = OPC_OP_IMM;
        w.i_fmt.funct3 = r[2:0];
        w.i_fmt.rd     = {3'b000, r[5:4]} + 5'd1;
        w.i_fmt.rs1    = {3'b000, r[7:6]} + 5'd1;
        w.i_fmt.imm12  = r[31:20];
        if (r[2:0] == 3'd1 || r[2:0] == 3'd5) begin
            w.i_fmt.imm12[11:5] = (r[2:0] == 3'd5 && r[3]) ? 7'h20 : 7'h00;
        end
        return w;
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        instr_u w;
        w.i_fmt.opcode = OPC_OP_IMM;
        w.i_fmt.funct3 = 3'd0;
        w.i_fmt.rd     = rd;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.imm12  = imm;
        return w;
    endfunction

    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= w;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instr_valid_i <= 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        idle(DRAIN_CYCLES);
        @(negedge clk);
        tests_done = tests_done + 1;
        if (top_errors + chk_errors == err_mark) begin
            $display("Test %0d %s: ok", tests_done, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_done, name,
                     top_errors + chk_errors - err_mark);
        end
        err_mark = top_errors + chk_errors;
    endtask

    initial begin
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rng           = 32'h219d;
        top_errors    = 0;
        err_mark      = 0;
        tests_done    = 0;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            if (wb_valid_o !== 1'b0) begin
                top_errors = top_errors + 1;
                $display("Fail at time %0t: wb_valid_o expected 0, actual %b", $time, wb_valid_o);
            end
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
        finish_test("reset");

        // Seed x1 to x4 so the R-type results are not all zero
        for (int i = 1; i <= 4; i++) begin
            rng = xorshift(rng);
            issue(addi_word(i[4:0], 5'd0, rng[11:0]));
        end
        repeat (N_RAND) begin
            rng = xorshift(rng);
            issue(r_word(rng));
        end
        finish_test("R-type back to back");

        repeat (N_RAND) begin
            rng = xorshift(rng);
            issue(i_word(rng));
        end
        finish_test("I-type back to back");

        repeat (N_RAND) begin
            rng = xorshift(rng);
            issue(rng[10] ? r_word(rng) : i_word(rng));
            idle(int'(rng[12:11]));
        end
        finish_test("mix with gaps");

        repeat (N_SPECIAL / 4) begin
            rng = xorshift(rng);
            issue(r_word(rng) & ~(32'h1f << 7));
            issue(addi_word(5'd0, rng[14:10], rng[31:20]));
            word = rng;
            if (word[6:0] == OPC_OP || word[6:0] == OPC_OP_IMM) begin
                word[6] = ~word[6];
            end
            issue(word);
            issue(addi_word(5'd5, 5'd0, 12'd0));
        end
        finish_test("x0 and other opcodes");

        $display("Tests run: %0d, write-backs checked: %0d, errors: %0d",
                 tests_done, chk_checks, top_errors + chk_errors);
        if (top_errors + chk_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
